// File: uart_pkg.sv
// uart_pkg
// shared constants, APB register map and state types for the APB UART

`default_nettype none

package uart_pkg;

    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;
    localparam int DATA_WIDTH     = 8;
    localparam int DIV_WIDTH      = 16;
    localparam int MIN_DIVIDER    = 4;
    localparam int FIFO_DEPTH     = 16;

    // register map, byte addresses
    localparam logic [APB_ADDR_WIDTH-1:0] CLK_DIVIDER_ADDR = 8'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] CONTROL_ADDR     = 8'h04;
    localparam logic [APB_ADDR_WIDTH-1:0] STATUS_ADDR      = 8'h08;
    localparam logic [APB_ADDR_WIDTH-1:0] TX_DATA_ADDR     = 8'h0C;
    localparam logic [APB_ADDR_WIDTH-1:0] RX_DATA_ADDR     = 8'h10;

    // CONTROL fields, parity mode takes two bits from CTRL_PARITY_LSB
    localparam int CTRL_TX_EN      = 0;
    localparam int CTRL_RX_EN      = 1;
    localparam int CTRL_PARITY_LSB = 2;

    localparam int STAT_RX_EMPTY   = 0;
    localparam int STAT_TX_FULL    = 1;
    localparam int STAT_PARITY_ERR = 2;

    // the unused encoding 3 behaves as no parity in both shifters
    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2
    } parity_mode_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

endpackage

`default_nettype wire

// File: sync_fifo.sv
// sync_fifo
// single-clock FIFO with a valid/ready stream on the write and read sides

`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             wr_valid_i,
    input  logic [WIDTH-1:0] wr_data_i,
    output logic             wr_ready_o,
    output logic             rd_valid_o,
    output logic [WIDTH-1:0] rd_data_o,
    input  logic             rd_ready_i
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       push;
    logic                       pop;

    assign wr_ready_o = (int'(count) < DEPTH);
    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];
    assign push       = wr_valid_i && wr_ready_o;
    assign pop        = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap explicitly so DEPTH need not be a power of two
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i) int'(count) <= DEPTH);

    // the head entry must not move under a stalled reader
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        rd_valid_o && !rd_ready_i |=> $stable(rd_data_o));

endmodule

`default_nettype wire

// File: uart_tx.sv
// uart_tx
// serializer from a valid/ready byte stream to a UART frame with start bit,
// LSB-first data, optional parity and one stop bit

`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic [uart_pkg::DIV_WIDTH-1:0]  divider_i,
    input  uart_pkg::parity_mode_e          parity_i,
    input  logic                            s_valid_i,
    input  logic [uart_pkg::DATA_WIDTH-1:0] s_data_i,
    output logic                            s_ready_o,
    output logic                            uart_tx_o
);

    import uart_pkg::*;

    tx_state_e                     state;
    logic [DIV_WIDTH-1:0]          div_q;
    logic [DIV_WIDTH-1:0]          cnt;
    logic [$clog2(DATA_WIDTH)-1:0] bit_idx;
    logic [DATA_WIDTH-1:0]         shift_q;
    logic                          par_en_q;
    logic                          par_acc;
    logic                          tx_q;
    logic                          bit_done;

    assign s_ready_o = (state == TX_IDLE);
    assign uart_tx_o = tx_q;
    assign bit_done  = (cnt == div_q - 1'b1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state <= TX_IDLE;
            tx_q  <= 1'b1;
        end else begin
            cnt <= bit_done ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    // divider and parity are frozen for the whole frame
                    if (s_valid_i) begin
                        state    <= TX_START;
                        tx_q     <= 1'b0;
                        cnt      <= '0;
                        div_q    <= divider_i;
                        shift_q  <= s_data_i;
                        par_en_q <= (parity_i == PARITY_EVEN) || (parity_i == PARITY_ODD);
                        par_acc  <= (parity_i == PARITY_ODD);
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx_q    <= shift_q[0];
                        par_acc <= par_acc ^ shift_q[0];
                        shift_q <= shift_q >> 1;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (int'(bit_idx) == DATA_WIDTH - 1) begin
                            state <= par_en_q ? TX_PARITY : TX_STOP;
                            tx_q  <= par_en_q ? par_acc : 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_q    <= shift_q[0];
                            par_acc <= par_acc ^ shift_q[0];
                            shift_q <= shift_q >> 1;
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_done) begin
                        state <= TX_STOP;
                        tx_q  <= 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // the receiver needs a few cycles per bit to find the middle of each bit
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        s_valid_i && s_ready_o |-> divider_i >= MIN_DIVIDER);

endmodule

`default_nettype wire

// File: uart_rx.sv
// uart_rx
// deserializer with start detection, mid-bit sampling and a parity check,
// delivering each byte as a one-cycle valid pulse

`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic [uart_pkg::DIV_WIDTH-1:0]  divider_i,
    input  uart_pkg::parity_mode_e          parity_i,
    input  logic                            uart_rx_i,
    output logic                            m_valid_o,
    output logic [uart_pkg::DATA_WIDTH-1:0] m_data_o,
    output logic                            parity_err_o
);

    import uart_pkg::*;

    rx_state_e                     state;
    logic                          rx_meta;
    logic                          rx_sync;
    logic                          rx_prev;
    logic [DIV_WIDTH-1:0]          div_q;
    logic [DIV_WIDTH-1:0]          cnt;
    logic [$clog2(DATA_WIDTH)-1:0] bit_idx;
    logic [DATA_WIDTH-1:0]         shift_q;
    logic                          par_en_q;
    logic                          par_acc;
    logic                          par_bad;
    logic                          bit_done;

    assign m_data_o = shift_q;
    assign bit_done = (cnt == div_q - 1'b1);

    // the line idles high, so the synchronizer resets to one
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state        <= RX_IDLE;
            m_valid_o    <= 1'b0;
            parity_err_o <= 1'b0;
        end else begin
            m_valid_o    <= 1'b0;
            parity_err_o <= 1'b0;
            cnt          <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        state    <= RX_START;
                        cnt      <= '0;
                        div_q    <= divider_i;
                        par_en_q <= (parity_i == PARITY_EVEN) || (parity_i == PARITY_ODD);
                        par_acc  <= (parity_i == PARITY_ODD);
                        par_bad  <= 1'b0;
                    end
                end
                RX_START: begin
                    // a glitch shorter than half a bit is not a start bit
                    if (cnt == (div_q >> 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        cnt     <= '0;
                        shift_q <= {rx_sync, shift_q[DATA_WIDTH-1:1]};
                        par_acc <= par_acc ^ rx_sync;
                        if (int'(bit_idx) == DATA_WIDTH - 1) begin
                            state <= par_en_q ? RX_PARITY : RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_done) begin
                        cnt     <= '0;
                        par_bad <= (rx_sync != par_acc);
                        state   <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    // leave at mid stop bit so the next falling edge is seen
                    if (bit_done) begin
                        state        <= RX_IDLE;
                        m_valid_o    <= 1'b1;
                        parity_err_o <= par_bad;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i) m_valid_o |=> !m_valid_o);

endmodule

`default_nettype wire

// File: apb_uart.sv
// apb_uart
// APB3 register block around a UART, with a transmit and a receive FIFO
// between the registers and the two shifters

`timescale 1ns/1ns
`default_nettype none

module apb_uart (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [uart_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [uart_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
    output logic [uart_pkg::APB_DATA_WIDTH-1:0] prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    input  logic                                uart_rx_i,
    output logic                                uart_tx_o
);

    import uart_pkg::*;

    logic                       access;
    logic                       wr_access;
    logic                       rd_access;
    logic [DIV_WIDTH-1:0]       divider_q;
    logic [CTRL_PARITY_LSB+1:0] control_q;
    parity_mode_e               parity_mode;
    logic                       tx_rstn;
    logic                       rx_rstn;
    logic [DATA_WIDTH-1:0]      tx_hold_q;
    logic                       tx_hold_valid_q;
    logic                       tx_hold_free;
    logic                       tx_load;
    logic                       parity_err_q;
    logic                       status_rd;
    logic                       rx_pop;
    logic                       tx_fifo_wr_ready;
    logic                       tx_fifo_rd_valid;
    logic [DATA_WIDTH-1:0]      tx_fifo_rd_data;
    logic                       tx_shift_ready;
    logic                       rx_shift_valid;
    logic [DATA_WIDTH-1:0]      rx_shift_data;
    logic                       rx_shift_perr;
    logic                       rx_fifo_rd_valid;
    logic [DATA_WIDTH-1:0]      rx_fifo_rd_data;

    assign access    = psel_i && penable_i;
    assign wr_access = access && pwrite_i;
    assign rd_access = access && !pwrite_i;
    assign pslverr_o = 1'b0;

    // a cleared enable bit holds that direction's FIFO and shifter in reset
    assign tx_rstn     = rstn_i && control_q[CTRL_TX_EN];
    assign rx_rstn     = rstn_i && control_q[CTRL_RX_EN];
    assign parity_mode = parity_mode_e'(control_q[CTRL_PARITY_LSB +: 2]);

    // the holding register frees up on the same edge the FIFO takes its byte
    assign tx_hold_free = !tx_hold_valid_q || tx_fifo_wr_ready;
    assign tx_load      = wr_access && (paddr_i == TX_DATA_ADDR) && tx_hold_free;
    assign status_rd    = rd_access && (paddr_i == STATUS_ADDR);
    assign rx_pop       = rd_access && (paddr_i == RX_DATA_ADDR);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            divider_q       <= '0;
            control_q       <= '0;
            tx_hold_valid_q <= 1'b0;
            parity_err_q    <= 1'b0;
        end else begin
            if (wr_access && (paddr_i == CLK_DIVIDER_ADDR)) begin
                divider_q <= pwdata_i[DIV_WIDTH-1:0];
            end
            if (wr_access && (paddr_i == CONTROL_ADDR)) begin
                control_q <= pwdata_i[CTRL_PARITY_LSB+1:0];
            end
            if (tx_load) begin
                tx_hold_valid_q <= 1'b1;
            end else if (tx_fifo_wr_ready) begin
                tx_hold_valid_q <= 1'b0;
            end
            // a new error in the cycle of a STATUS read stays pending
            if (rx_shift_perr) begin
                parity_err_q <= 1'b1;
            end else if (status_rd) begin
                parity_err_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_load) begin
            tx_hold_q <= pwdata_i[DATA_WIDTH-1:0];
        end
    end

    always_comb begin
        pready_o = 1'b1;
        if (wr_access && (paddr_i == TX_DATA_ADDR)) begin
            pready_o = tx_hold_free;
        end else if (rx_pop) begin
            pready_o = rx_fifo_rd_valid;
        end
    end

    always_comb begin
        prdata_o = '0;
        if (rd_access) begin
            case (paddr_i)
                CLK_DIVIDER_ADDR: prdata_o = APB_DATA_WIDTH'(divider_q);
                CONTROL_ADDR:     prdata_o = APB_DATA_WIDTH'(control_q);
                STATUS_ADDR: begin
                    prdata_o[STAT_RX_EMPTY]   = !rx_fifo_rd_valid;
                    prdata_o[STAT_TX_FULL]    = !tx_fifo_wr_ready;
                    prdata_o[STAT_PARITY_ERR] = parity_err_q;
                end
                RX_DATA_ADDR:     prdata_o = APB_DATA_WIDTH'(rx_fifo_rd_data);
                default:          prdata_o = '0;
            endcase
        end
    end

    sync_fifo #(
        .DEPTH(FIFO_DEPTH),
        .WIDTH(DATA_WIDTH)
    ) u_tx_fifo (
        .clk_i     (clk_i),
        .rstn_i    (tx_rstn),
        .wr_valid_i(tx_hold_valid_q),
        .wr_data_i (tx_hold_q),
        .wr_ready_o(tx_fifo_wr_ready),
        .rd_valid_o(tx_fifo_rd_valid),
        .rd_data_o (tx_fifo_rd_data),
        .rd_ready_i(tx_shift_ready)
    );

    uart_tx u_uart_tx (
        .clk_i    (clk_i),
        .rstn_i   (tx_rstn),
        .divider_i(divider_q),
        .parity_i (parity_mode),
        .s_valid_i(tx_fifo_rd_valid),
        .s_data_i (tx_fifo_rd_data),
        .s_ready_o(tx_shift_ready),
        .uart_tx_o(uart_tx_o)
    );

    uart_rx u_uart_rx (
        .clk_i       (clk_i),
        .rstn_i      (rx_rstn),
        .divider_i   (divider_q),
        .parity_i    (parity_mode),
        .uart_rx_i   (uart_rx_i),
        .m_valid_o   (rx_shift_valid),
        .m_data_o    (rx_shift_data),
        .parity_err_o(rx_shift_perr)
    );

    // the receiver cannot stall the line, so a byte that finds the FIFO full is lost
    sync_fifo #(
        .DEPTH(FIFO_DEPTH),
        .WIDTH(DATA_WIDTH)
    ) u_rx_fifo (
        .clk_i     (clk_i),
        .rstn_i    (rx_rstn),
        .wr_valid_i(rx_shift_valid),
        .wr_data_i (rx_shift_data),
        .wr_ready_o(),
        .rd_valid_o(rx_fifo_rd_valid),
        .rd_data_o (rx_fifo_rd_data),
        .rd_ready_i(rx_pop)
    );

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !pready_o |-> psel_i && penable_i);

endmodule

`default_nettype wire

// File: tb_apb_uart.sv
// tb_apb_uart
// directed testbench for the APB UART covering register access, loopback,
// parity generation and checking, transmit back-pressure and receive flush

`timescale 1ns/1ns
`default_nettype none

module tb_apb_uart;

    import uart_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_TESTS   = 6;
    localparam int MAX_DIV     = 64;
    localparam int FRAME_BITS  = 11;
    localparam int WATCHDOG_NS = NUM_TESTS * (FIFO_DEPTH + 2) * FRAME_BITS * MAX_DIV * CLK_PERIOD
                                 + 100000;

    logic                      clk_i;
    logic                      rstn_i;
    logic                      psel_i;
    logic                      penable_i;
    logic                      pwrite_i;
    logic [APB_ADDR_WIDTH-1:0] paddr_i;
    logic [APB_DATA_WIDTH-1:0] pwdata_i;
    logic [APB_DATA_WIDTH-1:0] prdata_o;
    logic                      pready_o;
    logic                      pslverr_o;
    logic                      uart_rx_i;
    logic                      uart_tx_o;
    logic                      loopback;
    logic                      rx_drive;
    logic [31:0]               lfsr_q;
    int                        cur_div;
    int                        last_waits;

    // the receive line comes either from the transmitter or from the tb driver
    assign uart_rx_i = loopback ? uart_tx_o : rx_drive;

    apb_uart UUT (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .psel_i   (psel_i),
        .penable_i(penable_i),
        .pwrite_i (pwrite_i),
        .paddr_i  (paddr_i),
        .pwdata_i (pwdata_i),
        .prdata_o (prdata_o),
        .pready_o (pready_o),
        .pslverr_o(pslverr_o),
        .uart_rx_i(uart_rx_i),
        .uart_tx_o(uart_tx_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit of the byte
    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b[i]   = lfsr_q[0];
        end
        return b;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic tx_en, input logic rx_en,
                                              input parity_mode_e mode);
        logic [31:0] w;
        w                        = '0;
        w[CTRL_TX_EN]            = tx_en;
        w[CTRL_RX_EN]            = rx_en;
        w[CTRL_PARITY_LSB +: 2]  = mode;
        return w;
    endfunction

    function automatic logic [31:0] status_word(input logic rx_empty, input logic tx_full,
                                                input logic perr);
        logic [31:0] w;
        w                  = '0;
        w[STAT_RX_EMPTY]   = rx_empty;
        w[STAT_TX_FULL]    = tx_full;
        w[STAT_PARITY_ERR] = perr;
        return w;
    endfunction

    // pready and prdata are sampled mid-cycle, where they hold the value of the next edge
    task automatic apb_access(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk_i);
        penable_i  = 1'b1;
        last_waits = 0;
        #1;
        while (!pready_o) begin
            last_waits++;
            @(negedge clk_i);
            #1;
        end
        rdata = prdata_o;
        check_equal("pslverr_o", 32'(pslverr_o), 32'h0);
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic read_expect(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] exp,
                               input string name);
        logic [31:0] data;
        apb_read(addr, data);
        check_equal(name, data, exp);
    endtask

    task automatic set_divider(input int div);
        apb_write(CLK_DIVIDER_ADDR, 32'(div));
        cur_div = div;
    endtask

    task automatic send_frame(input logic [7:0] data, input logic with_parity,
                              input logic par_bit);
        @(negedge clk_i);
        rx_drive = 1'b0;
        repeat (cur_div) @(negedge clk_i);
        for (int i = 0; i < DATA_WIDTH; i++) begin
            rx_drive = data[i];
            repeat (cur_div) @(negedge clk_i);
        end
        if (with_parity) begin
            rx_drive = par_bit;
            repeat (cur_div) @(negedge clk_i);
        end
        rx_drive = 1'b1;
        repeat (cur_div) @(negedge clk_i);
    endtask

    // even parity makes the count of ones even, odd parity makes it odd
    task automatic check_tx_frame(input logic [7:0] data, input parity_mode_e mode);
        logic exp_par;
        exp_par = (^data) ^ (mode == PARITY_ODD);
        @(negedge clk_i);
        while (uart_tx_o) @(negedge clk_i);
        repeat (cur_div / 2) @(negedge clk_i);
        check_equal("uart_tx_o start bit", 32'(uart_tx_o), 32'h0);
        for (int i = 0; i < DATA_WIDTH; i++) begin
            repeat (cur_div) @(negedge clk_i);
            check_equal("uart_tx_o data bit", 32'(uart_tx_o), 32'(data[i]));
        end
        if (mode == PARITY_EVEN || mode == PARITY_ODD) begin
            repeat (cur_div) @(negedge clk_i);
            check_equal("uart_tx_o parity bit", 32'(uart_tx_o), 32'(exp_par));
        end
        repeat (cur_div) @(negedge clk_i);
        check_equal("uart_tx_o stop bit", 32'(uart_tx_o), 32'h1);
    endtask

    task automatic test_reset_values();
        read_expect(CLK_DIVIDER_ADDR, 32'h0, "CLK_DIVIDER");
        read_expect(CONTROL_ADDR, 32'h0, "CONTROL");
        apb_write(CONTROL_ADDR, ctrl_word(1'b1, 1'b1, PARITY_NONE));
        read_expect(STATUS_ADDR, status_word(1'b1, 1'b0, 1'b0), "STATUS");
    endtask

    task automatic test_loopback();
        logic [7:0] sent [8];
        set_divider(8);
        loopback = 1'b1;
        for (int i = 0; i < 8; i++) begin
            sent[i] = random_byte();
            apb_write(TX_DATA_ADDR, {24'h0, sent[i]});
        end
        for (int i = 0; i < 8; i++) begin
            read_expect(RX_DATA_ADDR, {24'h0, sent[i]}, "RX_DATA");
        end
        read_expect(STATUS_ADDR, status_word(1'b1, 1'b0, 1'b0), "STATUS");
    endtask

    task automatic test_parity_modes();
        parity_mode_e mode;
        logic [7:0]   b;
        for (int m = 0; m < 2; m++) begin
            mode = (m == 0) ? PARITY_EVEN : PARITY_ODD;
            apb_write(CONTROL_ADDR, ctrl_word(1'b1, 1'b1, mode));
            for (int k = 0; k < 2; k++) begin
                b = random_byte();
                apb_write(TX_DATA_ADDR, {24'h0, b});
                check_tx_frame(b, mode);
                read_expect(RX_DATA_ADDR, {24'h0, b}, "RX_DATA");
            end
            read_expect(STATUS_ADDR, status_word(1'b1, 1'b0, 1'b0), "STATUS");
        end
    endtask

    task automatic test_parity_error();
        logic [7:0] b;
        loopback = 1'b0;
        apb_write(CONTROL_ADDR, ctrl_word(1'b1, 1'b1, PARITY_EVEN));
        b = random_byte();
        send_frame(b, 1'b1, ~(^b));
        read_expect(RX_DATA_ADDR, {24'h0, b}, "RX_DATA");
        read_expect(STATUS_ADDR, status_word(1'b1, 1'b0, 1'b1), "STATUS");
        read_expect(STATUS_ADDR, status_word(1'b1, 1'b0, 1'b0), "STATUS");
    endtask

    task automatic test_tx_backpressure();
        logic [7:0] sent [FIFO_DEPTH + 3];
        set_divider(MAX_DIV);
        apb_write(CONTROL_ADDR, ctrl_word(1'b1, 1'b1, PARITY_NONE));
        loopback = 1'b1;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            sent[i] = random_byte();
            apb_write(TX_DATA_ADDR, {24'h0, sent[i]});
        end
        read_expect(STATUS_ADDR, status_word(1'b1, 1'b1, 1'b0), "STATUS");
        // shifter, FIFO and holding register are all occupied now
        sent[FIFO_DEPTH + 2] = random_byte();
        apb_write(TX_DATA_ADDR, {24'h0, sent[FIFO_DEPTH + 2]});
        assert (last_waits > 0) else begin
            $display("TX_DATA write completed without a stall although the FIFO was full");
            $display("TB FAILED");
            $fatal(1);
        end
        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            read_expect(RX_DATA_ADDR, {24'h0, sent[i]}, "RX_DATA");
        end
    endtask

    task automatic test_rx_flush();
        set_divider(8);
        loopback = 1'b0;
        apb_write(CONTROL_ADDR, ctrl_word(1'b1, 1'b1, PARITY_NONE));
        for (int i = 0; i < 3; i++) begin
            send_frame(random_byte(), 1'b0, 1'b0);
        end
        read_expect(STATUS_ADDR, status_word(1'b0, 1'b0, 1'b0), "STATUS");
        apb_write(CONTROL_ADDR, ctrl_word(1'b1, 1'b0, PARITY_NONE));
        apb_write(CONTROL_ADDR, ctrl_word(1'b1, 1'b1, PARITY_NONE));
        read_expect(STATUS_ADDR, status_word(1'b1, 1'b0, 1'b0), "STATUS");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("TB FAILED");
        $fatal(1);
    end

    initial begin
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        rx_drive  = 1'b1;
        loopback  = 1'b0;
        lfsr_q    = 32'h43e2_307e;
        cur_div   = 0;
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;
        test_reset_values();
        test_loopback();
        test_parity_modes();
        test_parity_error();
        test_tx_backpressure();
        test_rx_flush();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
uart_pkg.sv
sync_fifo.sv
uart_tx.sv
uart_rx.sv
apb_uart.sv
tb_apb_uart.sv

// File: Makefile
# Verilator build and run of the APB UART testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_apb_uart
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '^TB PASSED$$' $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
